/* hw/vpipe_pkg.sv */
/*
 * Shared widths, encodings and the decoded instruction layout of the vector pipeline.
 * ALU encodings 24 to 31 are unused and execute as a zero result.
 */
package vpipe_pkg;

    localparam int INSTR_WIDTH = 32;
    localparam int SCALAR_WIDTH = 32;
    localparam int NUM_LANES = 4;
    localparam int NUM_REGS = 8;
    localparam int LANE_IDX_W = $clog2(NUM_LANES);

    // Instruction word fields
    localparam int INSTR_BRANCH_BIT = 31;
    localparam int INSTR_OP_HI = 30;
    localparam int INSTR_OP_LO = 26;
    localparam int INSTR_DEST_HI = 25;
    localparam int INSTR_DEST_LO = 23;
    localparam int INSTR_SRC1_HI = 22;
    localparam int INSTR_SRC1_LO = 20;
    localparam int INSTR_SRC2_HI = 19;
    localparam int INSTR_SRC2_LO = 17;
    localparam int INSTR_USE_IMM_BIT = 16;
    localparam int INSTR_MASK_HI = 15;
    localparam int INSTR_MASK_LO = 12;
    localparam int INSTR_IMM_HI = 11;
    localparam int INSTR_IMM_LO = 0;

    typedef logic [SCALAR_WIDTH-1:0] scalar_t;
    // Lane 0 in the low bits
    typedef scalar_t [NUM_LANES-1:0] vector_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [LANE_IDX_W-1:0] lane_idx_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [4:0] {
        OP_ASHR,
        OP_SHR,
        OP_SHL,
        OP_MOVE,
        OP_OR,
        OP_AND,
        OP_XOR,
        OP_ADD_I,
        OP_SUB_I,
        OP_CMPEQ_I,
        OP_CMPNE_I,
        OP_CMPGT_I,
        OP_CMPGE_I,
        OP_CMPLT_I,
        OP_CMPLE_I,
        OP_CMPGT_U,
        OP_CMPGE_U,
        OP_CMPLT_U,
        OP_CMPLE_U,
        OP_CLZ,
        OP_CTZ,
        OP_SEXT8,
        OP_SEXT16,
        OP_GETLANE
    } alu_op_t;

    typedef enum logic [1:0] {
        BRANCH_ZERO,
        BRANCH_NOT_ZERO,
        BRANCH_ALWAYS,
        BRANCH_REGISTER
    } branch_type_t;

    typedef enum logic {
        HS_IDLE,
        HS_ACKED
    } hs_state_t;

    typedef struct packed {
        scalar_t      pc;
        logic         is_branch;
        alu_op_t      alu_op;
        branch_type_t branch_type;
        reg_idx_t     dest;
        reg_idx_t     src1;
        reg_idx_t     src2;
        logic         use_imm;
        scalar_t      imm_value;
        lane_mask_t   mask;
    } decoded_instruction_t;

endpackage

/* hw/pipe_if.sv */
/*
 * Stage-to-stage bundles. Valid is a one-cycle flag; there is no ready signal
 * because the host handshake keeps issues at least two cycles apart.
 */
`timescale 1ns/100ps

// Operand fetch to execute
interface operand_if
    import vpipe_pkg::*;
();
    logic                 valid;
    decoded_instruction_t instr;
    vector_t              operand1;
    // Immediate broadcast to all lanes when use_imm is set
    vector_t              operand2;

    modport fetch(output valid, instr, operand1, operand2);
    modport execute(input valid, instr, operand1, operand2);
endinterface

// Execute to writeback, also tapped by operand fetch for bypass
interface result_if
    import vpipe_pkg::*;
();
    logic                 valid;
    decoded_instruction_t instr;
    vector_t              result;
    logic                 rollback_en;
    scalar_t              rollback_pc;

    modport execute(output valid, instr, result, rollback_en, rollback_pc);
    modport writeback(input valid, instr, result, rollback_en, rollback_pc);
    modport bypass(input valid, instr, result);
endinterface

/* hw/decode_stage.sv */
/*
 * Host side four-phase req/ack and instruction decode.
 * The host must hold instr_word and instr_pc stable while instr_req is high.
 */
`timescale 1ns/100ps

module decode_stage
    import vpipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_req,
    input  logic [INSTR_WIDTH-1:0] instr_word,
    input  scalar_t                instr_pc,
    input  logic                   rollback_en,
    output logic                   instr_ack,
    output logic                   dec_valid,
    output decoded_instruction_t   dec_instr
);
    hs_state_t hs_state;
    logic      accept;
    logic      captured;

    // One capture per req rise from idle
    assign accept = hs_state == HS_IDLE && instr_req;
    assign instr_ack = hs_state == HS_ACKED;

    // A redirect squashes whatever decode is holding
    assign dec_valid = captured && !rollback_en;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            hs_state <= HS_IDLE;
            captured <= 1'b0;
        end
        else
        begin
            captured <= accept;
            case (hs_state)
                HS_IDLE:
                    if (instr_req)
                        hs_state <= HS_ACKED;
                HS_ACKED:
                    if (!instr_req)
                        hs_state <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            dec_instr.pc <= instr_pc;
            dec_instr.is_branch <= instr_word[INSTR_BRANCH_BIT];
            dec_instr.alu_op <= alu_op_t'(instr_word[INSTR_OP_HI:INSTR_OP_LO]);
            dec_instr.branch_type <= branch_type_t'(instr_word[INSTR_OP_LO+1:INSTR_OP_LO]);
            dec_instr.dest <= instr_word[INSTR_DEST_HI:INSTR_DEST_LO];
            dec_instr.src1 <= instr_word[INSTR_SRC1_HI:INSTR_SRC1_LO];
            dec_instr.src2 <= instr_word[INSTR_SRC2_HI:INSTR_SRC2_LO];
            dec_instr.use_imm <= instr_word[INSTR_USE_IMM_BIT];
            dec_instr.mask <= instr_word[INSTR_MASK_HI:INSTR_MASK_LO];
            dec_instr.imm_value <= scalar_t'($signed(instr_word[INSTR_IMM_HI:INSTR_IMM_LO]));
        end
    end

    ack_follows_req: assert property (@(posedge clk) disable iff (reset)
        $rose(instr_ack) |-> $past(instr_req));

endmodule

/* hw/operand_fetch_stage.sv */
/*
 * Vector register file with masked lane writes, source reads and bypass.
 * Bypass covers only the instruction in the execute output register, which
 * is enough as long as decoded instructions are at least two cycles apart.
 */
`timescale 1ns/100ps

module operand_fetch_stage
    import vpipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dec_valid,
    input  decoded_instruction_t dec_instr,
    input  logic                 rollback_en,
    input  logic                 rf_write_en,
    input  reg_idx_t             rf_write_reg,
    input  lane_mask_t           rf_write_mask,
    input  vector_t              rf_write_data,
    operand_if.fetch             out,
    result_if.bypass             byp
);
    vector_t reg_file [NUM_REGS];
    vector_t src1_value;
    vector_t src2_value;
    logic    byp_usable;
    logic    byp_hit1;
    logic    byp_hit2;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int r = 0; r < NUM_REGS; r++)
                reg_file[r] <= '0;
        end
        else if (rf_write_en)
        begin
            for (int l = 0; l < NUM_LANES; l++)
                if (rf_write_mask[l])
                    reg_file[rf_write_reg][l] <= rf_write_data[l];
        end
    end

    // Branches carry no register result
    assign byp_usable = byp.valid && !byp.instr.is_branch;
    assign byp_hit1 = byp_usable && byp.instr.dest == dec_instr.src1;
    assign byp_hit2 = byp_usable && byp.instr.dest == dec_instr.src2;

    // Masked-off lanes still come from the file
    always_comb
    begin
        for (int l = 0; l < NUM_LANES; l++)
        begin
            src1_value[l] = byp_hit1 && byp.instr.mask[l] ? byp.result[l]
                : reg_file[dec_instr.src1][l];
            src2_value[l] = byp_hit2 && byp.instr.mask[l] ? byp.result[l]
                : reg_file[dec_instr.src2][l];
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            out.valid <= 1'b0;
        else
            out.valid <= dec_valid && !rollback_en;
    end

    always_ff @(posedge clk)
    begin
        out.instr <= dec_instr;
        out.operand1 <= src1_value;
        out.operand2 <= dec_instr.use_imm ? {NUM_LANES{dec_instr.imm_value}} : src2_value;
    end

    issue_spacing: assert property (@(posedge clk) disable iff (reset)
        dec_valid |=> !dec_valid);

endmodule

/* hw/int_execute_stage.sv */
/*
 * Single-cycle integer execute for all lanes plus branch resolution.
 * Compares return 0 or 1 per lane. CLZ and CTZ operate on operand2.
 * Unused ALU encodings give a zero result.
 */
`timescale 1ns/100ps

module int_execute_stage
    import vpipe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       rollback_en,
    operand_if.execute in,
    result_if.execute  out
);
    vector_t lane_results;
    logic    accept;
    logic    branch_taken;

    // Anything arriving during a redirect is younger than the branch
    assign accept = in.valid && !rollback_en;

    genvar lane;
    generate
        for (lane = 0; lane < NUM_LANES; lane++)
        begin : lane_alu
            scalar_t   op1;
            scalar_t   op2;
            scalar_t   diff;
            scalar_t   result;
            logic      borrow;
            logic      negative;
            logic      overflow;
            logic      zero;
            logic      signed_gtr;
            logic [5:0] lz;
            logic [5:0] tz;
            lane_idx_t src_lane;

            assign op1 = in.operand1[lane];
            assign op2 = in.operand2[lane];

            // Flags of op1 - op2 drive every compare
            assign {borrow, diff} = {1'b0, op1} - {1'b0, op2};
            assign negative = diff[SCALAR_WIDTH-1];
            assign overflow = op1[SCALAR_WIDTH-1] != op2[SCALAR_WIDTH-1]
                && negative == op2[SCALAR_WIDTH-1];
            assign zero = diff == '0;
            assign signed_gtr = overflow == negative;

            // Lanes counted from the top
            assign src_lane = lane_idx_t'(NUM_LANES - 1) - op2[LANE_IDX_W-1:0];

            always_comb
            begin
                lz = 6'd32;
                for (int b = 0; b < SCALAR_WIDTH; b++)
                    if (op2[b])
                        lz = 6'(SCALAR_WIDTH - 1 - b);
            end

            always_comb
            begin
                tz = 6'd32;
                for (int b = SCALAR_WIDTH - 1; b >= 0; b--)
                    if (op2[b])
                        tz = 6'(b);
            end

            always_comb
            begin
                case (in.instr.alu_op)
                    OP_ASHR: result = scalar_t'($signed(op1) >>> op2[4:0]);
                    OP_SHR: result = op1 >> op2[4:0];
                    OP_SHL: result = op1 << op2[4:0];
                    OP_MOVE: result = op2;
                    OP_OR: result = op1 | op2;
                    OP_AND: result = op1 & op2;
                    OP_XOR: result = op1 ^ op2;
                    OP_ADD_I: result = op1 + op2;
                    OP_SUB_I: result = diff;
                    OP_CMPEQ_I: result = scalar_t'(zero);
                    OP_CMPNE_I: result = scalar_t'(!zero);
                    OP_CMPGT_I: result = scalar_t'(signed_gtr && !zero);
                    OP_CMPGE_I: result = scalar_t'(signed_gtr || zero);
                    OP_CMPLT_I: result = scalar_t'(!signed_gtr && !zero);
                    OP_CMPLE_I: result = scalar_t'(!signed_gtr || zero);
                    OP_CMPGT_U: result = scalar_t'(!borrow && !zero);
                    OP_CMPGE_U: result = scalar_t'(!borrow || zero);
                    OP_CMPLT_U: result = scalar_t'(borrow && !zero);
                    OP_CMPLE_U: result = scalar_t'(borrow || zero);
                    OP_CLZ: result = scalar_t'(lz);
                    OP_CTZ: result = scalar_t'(tz);
                    OP_SEXT8: result = scalar_t'($signed(op2[7:0]));
                    OP_SEXT16: result = scalar_t'($signed(op2[15:0]));
                    OP_GETLANE: result = in.operand1[src_lane];
                    default: result = '0;
                endcase
            end

            assign lane_results[lane] = result;
        end
    endgenerate

    // Conditional branches test bit 0 of lane 0
    always_comb
    begin
        branch_taken = 1'b0;
        if (in.instr.is_branch)
        begin
            case (in.instr.branch_type)
                BRANCH_ZERO: branch_taken = !in.operand1[0][0];
                BRANCH_NOT_ZERO: branch_taken = in.operand1[0][0];
                default: branch_taken = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            out.valid <= 1'b0;
            out.rollback_en <= 1'b0;
        end
        else
        begin
            out.valid <= accept;
            out.rollback_en <= accept && branch_taken;
        end
    end

    always_ff @(posedge clk)
    begin
        out.instr <= in.instr;
        out.result <= lane_results;
        if (in.instr.branch_type == BRANCH_REGISTER)
            out.rollback_pc <= in.operand1[0];
        else
            out.rollback_pc <= in.instr.pc + in.instr.imm_value;
    end

    // Issue spacing leaves the execute output empty behind a taken branch
    no_result_behind_redirect: assert property (@(posedge clk) disable iff (reset)
        rollback_en |-> !out.valid);

endmodule

/* hw/writeback_stage.sv */
/*
 * Register file write request, retirement ports and redirect.
 * Branches never retire through wb_valid, taken or not.
 */
`timescale 1ns/100ps

module writeback_stage
    import vpipe_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    result_if.writeback  in,
    output logic         rollback_en,
    output logic         rf_write_en,
    output reg_idx_t     rf_write_reg,
    output lane_mask_t   rf_write_mask,
    output vector_t      rf_write_data,
    output logic         wb_valid,
    output reg_idx_t     wb_dest,
    output lane_mask_t   wb_mask,
    output vector_t      wb_result,
    output logic         redirect_valid,
    output scalar_t      redirect_pc
);
    // File is written on the same edge that raises wb_valid
    assign rf_write_en = in.valid && !in.instr.is_branch;
    assign rf_write_reg = in.instr.dest;
    assign rf_write_mask = in.instr.mask;
    assign rf_write_data = in.result;

    assign rollback_en = redirect_valid;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            wb_valid <= 1'b0;
            redirect_valid <= 1'b0;
        end
        else
        begin
            wb_valid <= rf_write_en;
            redirect_valid <= in.rollback_en;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rf_write_en)
        begin
            wb_dest <= in.instr.dest;
            wb_mask <= in.instr.mask;
            wb_result <= in.result;
        end
        if (in.rollback_en)
            redirect_pc <= in.rollback_pc;
    end

    retire_or_redirect: assert property (@(posedge clk) disable iff (reset)
        !(wb_valid && redirect_valid));

endmodule

/* hw/vector_core_top.sv */
/*
 * Four-lane vector integer pipeline for a single thread.
 * Result appears on wb_* three cycles after instr_ack rises.
 * The host must act on redirect_valid itself; nothing is fetched here.
 */
`timescale 1ns/100ps

module vector_core_top
    import vpipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_req,
    input  logic [INSTR_WIDTH-1:0] instr_word,
    input  scalar_t                instr_pc,
    output logic                   instr_ack,
    output logic                   wb_valid,
    output reg_idx_t               wb_dest,
    output lane_mask_t             wb_mask,
    output vector_t                wb_result,
    output logic                   redirect_valid,
    output scalar_t                redirect_pc
);
    logic                 dec_valid;
    decoded_instruction_t dec_instr;
    logic                 rollback_en;
    logic                 rf_write_en;
    reg_idx_t             rf_write_reg;
    lane_mask_t           rf_write_mask;
    vector_t              rf_write_data;

    operand_if opnd_bus();
    result_if  res_bus();

    decode_stage u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_req   (instr_req),
        .instr_word  (instr_word),
        .instr_pc    (instr_pc),
        .rollback_en (rollback_en),
        .instr_ack   (instr_ack),
        .dec_valid   (dec_valid),
        .dec_instr   (dec_instr)
    );

    operand_fetch_stage u_operand_fetch (
        .clk           (clk),
        .reset         (reset),
        .dec_valid     (dec_valid),
        .dec_instr     (dec_instr),
        .rollback_en   (rollback_en),
        .rf_write_en   (rf_write_en),
        .rf_write_reg  (rf_write_reg),
        .rf_write_mask (rf_write_mask),
        .rf_write_data (rf_write_data),
        .out           (opnd_bus.fetch),
        .byp           (res_bus.bypass)
    );

    int_execute_stage u_int_execute (
        .clk         (clk),
        .reset       (reset),
        .rollback_en (rollback_en),
        .in          (opnd_bus.execute),
        .out         (res_bus.execute)
    );

    writeback_stage u_writeback (
        .clk            (clk),
        .reset          (reset),
        .in             (res_bus.writeback),
        .rollback_en    (rollback_en),
        .rf_write_en    (rf_write_en),
        .rf_write_reg   (rf_write_reg),
        .rf_write_mask  (rf_write_mask),
        .rf_write_data  (rf_write_data),
        .wb_valid       (wb_valid),
        .wb_dest        (wb_dest),
        .wb_mask        (wb_mask),
        .wb_result      (wb_result),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

/* testbench/tb_model.svh */
/*
 * Reference model of the ALU lanes, branches and register file, plus the LFSR.
 * Included inside the testbench module, which imports vpipe_pkg.
 */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef struct packed {
    logic        is_redirect;
    reg_idx_t    dest;
    lane_mask_t  mask;
    vector_t     result;
    scalar_t     target;
    logic [31:0] accept_cycle;
} expect_t;

// Expected retirements and redirects in issue order
expect_t     exp_q[$];
// Issue-time view of the file that is rolled back to the retired view on a redirect
vector_t     spec_regs[NUM_REGS] = '{default: '0};
vector_t     retired_regs[NUM_REGS] = '{default: '0};
logic [15:0] lfsr_state = 16'd8;

// One step of x^16 + x^14 + x^13 + x^11 + 1 per bit taken
function automatic logic [31:0] lfsr_bits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++)
    begin
        feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], feedback};
        value = {value[30:0], feedback};
    end
    return value;
endfunction

function automatic scalar_t lane_result(input logic [4:0] op, input scalar_t a,
    input scalar_t b, input vector_t op1_vec);
    int n;
    n = 0;
    case (op)
        OP_ASHR: return scalar_t'($signed(a) >>> b[4:0]);
        OP_SHR: return a >> b[4:0];
        OP_SHL: return a << b[4:0];
        OP_MOVE: return b;
        OP_OR: return a | b;
        OP_AND: return a & b;
        OP_XOR: return a ^ b;
        OP_ADD_I: return a + b;
        OP_SUB_I: return a - b;
        OP_CMPEQ_I: return scalar_t'(a == b);
        OP_CMPNE_I: return scalar_t'(a != b);
        OP_CMPGT_I: return scalar_t'($signed(a) > $signed(b));
        OP_CMPGE_I: return scalar_t'($signed(a) >= $signed(b));
        OP_CMPLT_I: return scalar_t'($signed(a) < $signed(b));
        OP_CMPLE_I: return scalar_t'($signed(a) <= $signed(b));
        OP_CMPGT_U: return scalar_t'(a > b);
        OP_CMPGE_U: return scalar_t'(a >= b);
        OP_CMPLT_U: return scalar_t'(a < b);
        OP_CMPLE_U: return scalar_t'(a <= b);
        OP_CLZ:
        begin
            while (n < 32 && !b[31 - n])
                n++;
            return scalar_t'(n);
        end
        OP_CTZ:
        begin
            while (n < 32 && !b[n])
                n++;
            return scalar_t'(n);
        end
        OP_SEXT8: return {{24{b[7]}}, b[7:0]};
        OP_SEXT16: return {{16{b[15]}}, b[15:0]};
        // Lanes counted down from lane 3
        OP_GETLANE: return op1_vec[NUM_LANES - 1 - int'(b[1:0])];
        default: return '0;
    endcase
endfunction

function automatic void model_issue(input logic [31:0] word, input scalar_t pc,
    input int accept_cycle);
    expect_t    e;
    vector_t    op1;
    vector_t    op2;
    scalar_t    imm;
    logic       taken;
    reg_idx_t   dest;
    lane_mask_t mask;
    logic [1:0] btype;
    dest = word[INSTR_DEST_HI:INSTR_DEST_LO];
    mask = word[INSTR_MASK_HI:INSTR_MASK_LO];
    btype = word[INSTR_OP_LO+1:INSTR_OP_LO];
    imm = {{20{word[INSTR_IMM_HI]}}, word[INSTR_IMM_HI:INSTR_IMM_LO]};
    op1 = spec_regs[word[INSTR_SRC1_HI:INSTR_SRC1_LO]];
    op2 = word[INSTR_USE_IMM_BIT] ? {NUM_LANES{imm}}
        : spec_regs[word[INSTR_SRC2_HI:INSTR_SRC2_LO]];
    e = '0;
    e.accept_cycle = accept_cycle;
    if (word[INSTR_BRANCH_BIT])
    begin
        case (btype)
            BRANCH_ZERO: taken = op1[0][0] == 1'b0;
            BRANCH_NOT_ZERO: taken = op1[0][0] == 1'b1;
            default: taken = 1'b1;
        endcase
        e.is_redirect = 1'b1;
        e.target = btype == BRANCH_REGISTER ? op1[0] : pc + imm;
        // A branch that falls through leaves no trace at the outputs
        if (taken)
            exp_q.push_back(e);
    end
    else
    begin
        e.dest = dest;
        e.mask = mask;
        for (int l = 0; l < NUM_LANES; l++)
        begin
            e.result[l] = lane_result(word[INSTR_OP_HI:INSTR_OP_LO], op1[l], op2[l], op1);
            if (mask[l])
                spec_regs[dest][l] = e.result[l];
        end
        exp_q.push_back(e);
    end
endfunction

`endif

/* testbench/tb_vector_core.sv */
/*
 * Self-checking testbench for vector_core_top. Inputs change on the falling
 * edge and outputs are checked there against the model in tb_model.svh.
 */
`timescale 1ns/100ps

module tb_vector_core
    import vpipe_pkg::*;
();
    localparam int WAIT_LIMIT = 50;

    logic        clk;
    logic        reset;
    logic        instr_req;
    logic [31:0] instr_word;
    scalar_t     instr_pc;
    logic        instr_ack;
    logic        wb_valid;
    reg_idx_t    wb_dest;
    lane_mask_t  wb_mask;
    vector_t     wb_result;
    logic        redirect_valid;
    scalar_t     redirect_pc;

    int          cycle_count = 0;
    int          errors = 0;
    int          failed_tests = 0;
    int          test_count = 0;
    int          errors_at_start = 0;
    int          discarded = 0;
    logic        prev_ack = 1'b0;
    logic        timed_out = 1'b0;
    scalar_t     next_pc = 32'h0000_1000;
    string       test_name;

    `include "tb_model.svh"

    vector_core_top u_dut (
        .clk            (clk),
        .reset          (reset),
        .instr_req      (instr_req),
        .instr_word     (instr_word),
        .instr_pc       (instr_pc),
        .instr_ack      (instr_ack),
        .wb_valid       (wb_valid),
        .wb_dest        (wb_dest),
        .wb_mask        (wb_mask),
        .wb_result      (wb_result),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    task automatic report_mismatch(input string name, input logic [127:0] expected,
        input logic [127:0] actual);
        $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR at %0t: timed out waiting for %s", $time, what);
        errors++;
        timed_out = 1'b1;
    endtask

    // Runs at every falling edge before any new stimulus
    task automatic check_outputs();
        expect_t e;
        if (instr_ack && !prev_ack)
            assert (instr_req) else report_failure("instr_ack rose while instr_req was low");
        if (!instr_ack && prev_ack)
            assert (!instr_req) else report_failure("instr_ack fell while instr_req was high");
        prev_ack = instr_ack;
        if (wb_valid || redirect_valid)
        begin
            if (exp_q.size() == 0)
                report_failure("retirement or redirect with nothing outstanding");
            else
            begin
                e = exp_q.pop_front();
                assert (cycle_count == e.accept_cycle + 3)
                else report_mismatch("retire cycle", 128'(e.accept_cycle + 3), 128'(cycle_count));
                if (wb_valid)
                begin
                    assert (!e.is_redirect) else report_failure("wb_valid instead of a redirect");
                    assert (wb_dest == e.dest)
                    else report_mismatch("wb_dest", 128'(e.dest), 128'(wb_dest));
                    assert (wb_mask == e.mask)
                    else report_mismatch("wb_mask", 128'(e.mask), 128'(wb_mask));
                    assert (wb_result == e.result)
                    else report_mismatch("wb_result", e.result, wb_result);
                    for (int l = 0; l < NUM_LANES; l++)
                        if (e.mask[l])
                            retired_regs[e.dest][l] = e.result[l];
                end
                else
                begin
                    assert (e.is_redirect) else report_failure("redirect without a taken branch");
                    assert (redirect_pc == e.target)
                    else report_mismatch("redirect_pc", 128'(e.target), 128'(redirect_pc));
                    // Everything younger than the branch is squashed
                    discarded += exp_q.size();
                    exp_q.delete();
                    spec_regs = retired_regs;
                end
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        check_outputs();
    endtask

    function automatic logic [31:0] make_word(input logic is_branch, input logic [4:0] op,
        input reg_idx_t dest, input reg_idx_t src1, input reg_idx_t src2,
        input logic use_imm, input lane_mask_t mask, input logic [11:0] imm);
        logic [31:0] w;
        w = '0;
        w[INSTR_BRANCH_BIT] = is_branch;
        w[INSTR_OP_HI:INSTR_OP_LO] = op;
        w[INSTR_DEST_HI:INSTR_DEST_LO] = dest;
        w[INSTR_SRC1_HI:INSTR_SRC1_LO] = src1;
        w[INSTR_SRC2_HI:INSTR_SRC2_LO] = src2;
        w[INSTR_USE_IMM_BIT] = use_imm;
        w[INSTR_MASK_HI:INSTR_MASK_LO] = mask;
        w[INSTR_IMM_HI:INSTR_IMM_LO] = imm;
        return w;
    endfunction

    // Four-phase handshake as fast as the DUT allows
    task automatic issue(input logic [31:0] word);
        int waited;
        waited = 0;
        while (instr_ack && !timed_out)
        begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT)
                report_timeout("instr_ack to fall");
        end
        if (!timed_out)
        begin
            // Accepted on the next rising edge since ack is low
            model_issue(word, next_pc, cycle_count + 1);
            instr_word = word;
            instr_pc = next_pc;
            instr_req = 1'b1;
            next_pc += 4;
            waited = 0;
            while (!instr_ack && !timed_out)
            begin
                next_cycle();
                waited++;
                if (waited > WAIT_LIMIT)
                    report_timeout("instr_ack to rise");
            end
            instr_req = 1'b0;
        end
    endtask

    task automatic move_imm(input reg_idx_t dest, input lane_mask_t mask, input logic [11:0] imm);
        issue(make_word(1'b0, OP_MOVE, dest, 3'd0, 3'd0, 1'b1, mask, imm));
    endtask

    task automatic branch_on(input branch_type_t btype, input reg_idx_t src1,
        input logic [11:0] imm);
        issue(make_word(1'b1, {3'b000, btype}, 3'd0, src1, 3'd0, 1'b0, 4'h0, imm));
    endtask

    task automatic random_alu(input logic [4:0] op);
        reg_idx_t    dest;
        reg_idx_t    src1;
        reg_idx_t    src2;
        logic        use_imm;
        lane_mask_t  mask;
        logic [11:0] imm;
        dest = reg_idx_t'(lfsr_bits(3));
        src1 = reg_idx_t'(lfsr_bits(3));
        src2 = reg_idx_t'(lfsr_bits(3));
        use_imm = lfsr_bits(1) != 0;
        mask = lane_mask_t'(lfsr_bits(4));
        imm = 12'(lfsr_bits(12));
        issue(make_word(1'b0, op, dest, src1, src2, use_imm, mask, imm));
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && !timed_out)
        begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT)
                report_timeout("outstanding retirements");
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        test_count++;
        if (errors == errors_at_start)
            $display("test %0d %s: passed", test_count, test_name);
        else
        begin
            failed_tests++;
            $display("test %0d %s: %0d checks failed", test_count, test_name,
                errors - errors_at_start);
        end
    endtask

    initial
    begin
        int discarded_before;
        clk = 1'b0;
        reset = 1'b1;
        instr_req = 1'b0;
        instr_word = '0;
        instr_pc = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        begin_test("reset state");
        next_cycle();
        assert (!instr_ack) else report_mismatch("instr_ack", 128'(0), 128'(instr_ack));
        assert (!wb_valid) else report_mismatch("wb_valid", 128'(0), 128'(wb_valid));
        assert (!redirect_valid)
        else report_mismatch("redirect_valid", 128'(0), 128'(redirect_valid));
        end_test();

        begin_test("handshake and retire order");
        for (int r = 0; r < NUM_REGS; r++)
            move_imm(reg_idx_t'(r), 4'hf, 12'(lfsr_bits(12)));
        for (int r = 0; r < NUM_REGS; r++)
            move_imm(reg_idx_t'(r), lane_mask_t'(lfsr_bits(4)), 12'(lfsr_bits(12)));
        drain();
        end_test();

        begin_test("random alu operations");
        for (int op = 0; op < 32; op++)
            for (int k = 0; k < 3; k++)
                random_alu(5'(op));
        issue(make_word(1'b0, OP_CLZ, 3'd1, 3'd0, 3'd0, 1'b1, 4'hf, 12'd0));
        issue(make_word(1'b0, OP_CTZ, 3'd2, 3'd0, 3'd0, 1'b1, 4'hf, 12'd0));
        drain();
        end_test();

        begin_test("masked lanes");
        move_imm(3'd5, 4'hf, 12'h123);
        move_imm(3'd5, 4'b0101, 12'hffb);
        move_imm(3'd4, 4'hf, 12'h055);
        issue(make_word(1'b0, OP_MOVE, 3'd6, 3'd0, 3'd5, 1'b0, 4'hf, 12'd0));
        drain();
        end_test();

        begin_test("back to back bypass");
        move_imm(3'd2, 4'hf, 12'h010);
        move_imm(3'd2, 4'b0011, 12'h7ff);
        issue(make_word(1'b0, OP_ADD_I, 3'd3, 3'd2, 3'd2, 1'b0, 4'hf, 12'd0));
        drain();
        end_test();

        begin_test("branches and redirect");
        discarded_before = discarded;
        move_imm(3'd0, 4'hf, 12'h000);
        move_imm(3'd1, 4'hf, 12'h001);
        move_imm(3'd3, 4'hf, 12'h400);
        branch_on(BRANCH_ZERO, 3'd0, 12'h040);
        move_imm(3'd7, 4'hf, 12'h111);
        move_imm(3'd7, 4'hf, 12'h222);
        branch_on(BRANCH_NOT_ZERO, 3'd0, 12'h010);
        move_imm(3'd6, 4'hf, 12'h333);
        branch_on(BRANCH_NOT_ZERO, 3'd1, 12'hf80);
        move_imm(3'd6, 4'hf, 12'h444);
        move_imm(3'd6, 4'hf, 12'h555);
        branch_on(BRANCH_ALWAYS, 3'd0, 12'h100);
        move_imm(3'd5, 4'hf, 12'h666);
        move_imm(3'd5, 4'hf, 12'h777);
        branch_on(BRANCH_REGISTER, 3'd3, 12'h000);
        move_imm(3'd4, 4'hf, 12'h088);
        move_imm(3'd4, 4'hf, 12'h099);
        branch_on(BRANCH_ZERO, 3'd1, 12'h020);
        issue(make_word(1'b0, OP_MOVE, 3'd2, 3'd0, 3'd7, 1'b0, 4'hf, 12'd0));
        drain();
        // One follower of each of the four taken branches lands in its shadow
        assert (discarded - discarded_before == 4)
        else report_mismatch("discarded count", 128'(4), 128'(discarded - discarded_before));
        end_test();

        $display("%0d tests, %0d failed, %0d failed checks, %0d instructions discarded",
            test_count, failed_tests, errors, discarded);
        if (errors == 0 && !timed_out)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* compile.f */
+incdir+testbench
hw/vpipe_pkg.sv
hw/pipe_if.sv
hw/decode_stage.sv
hw/operand_fetch_stage.sv
hw/int_execute_stage.sv
hw/writeback_stage.sv
hw/vector_core_top.sv
testbench/tb_vector_core.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_vector_core \
    -f compile.f -o sim_vector_core
./obj_dir/sim_vector_core > sim.log 2>&1
cat sim.log

if grep -q '\*\* PASS \*\*' sim.log; then
    exit 0
fi
exit 1
